/* design/crossbarSender.sv */
`default_nettype none
`timescale 1ns/10ps

module crossbarSender (
  input  logic                     clk,
  input  logic                     rst,
  input  nocRouterPkg::arbStateE   grant,
  input  logic [4:0]               bufValid,
  input  nocRouterPkg::flitT [4:0] bufFlit,
  output logic [4:0]               popVec,
  output logic                     sent,
  output nocRouterPkg::flitT       sentFlit,
  output logic                     outReq,
  output nocRouterPkg::flitT       outFlit,
  input  logic                     outAck
);

  import nocRouterPkg::*;

  typedef enum logic [1:0] {
    sendIdle,
    sendReq,
    sendWaitAckLow
  } sendStateE;

  sendStateE           sendState;
  logic                selValid;
  flitT                selFlit;
  logic [numPorts-1:0] srcVec;

  // ##############################
  // input select
  // ##############################

  always_comb
  begin
    selValid = 1'b0;
    selFlit  = '0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (grant[i+1])
      begin
        selValid = bufValid[i];
        selFlit  = bufFlit[i];
      end
    end
  end

  // ##############################
  // four-phase output link
  // ##############################

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sendState <= sendIdle;
      outReq    <= 1'b0;
      popVec    <= '0;
      sent      <= 1'b0;
    end
    else
    begin
      popVec <= '0;
      sent   <= 1'b0;
      case (sendState)
        sendIdle:
        begin
          if (selValid)
          begin
            outReq    <= 1'b1;
            sendState <= sendReq;
          end
        end
        sendReq:
        begin
          if (outAck)
          begin
            outReq    <= 1'b0;
            popVec    <= srcVec;
            sent      <= 1'b1;
            sendState <= sendWaitAckLow;
          end
        end
        default:
        begin
          if (!outAck)
          begin
            sendState <= sendIdle;
          end
        end
      endcase
    end
  end

  // flit and source are loaded only while idle, so both hold for the whole handshake.
  always_ff @(posedge clk)
  begin
    if ((sendState == sendIdle) && selValid)
    begin
      outFlit <= selFlit;
      srcVec  <= grant[numPorts:1];
    end
  end

  assign sentFlit = outFlit;

endmodule

`default_nettype wire

/* design/linkReceiver.sv */
`default_nettype none
`timescale 1ns/10ps

module linkReceiver #(
  parameter logic [nocRouterPkg::coordWidth-1:0] routerX = '0,
  parameter logic [nocRouterPkg::coordWidth-1:0] routerY = '0
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               inReq,
  input  nocRouterPkg::flitT inFlit,
  output logic               inAck,
  input  logic               pop,
  output logic               bufValid,
  output nocRouterPkg::flitT bufFlit,
  output logic [4:0]         reqVec
);

  import nocRouterPkg::*;

  headerT hdrIn;
  portE   route;
  logic   capture;

  // dimension order routing, X first and then Y.
  function automatic portE xyRoute(headerT hdr);
    portE dir;
    if (hdr.destX > routerX)
    begin
      dir = portEast;
    end
    else if (hdr.destX < routerX)
    begin
      dir = portWest;
    end
    else if (hdr.destY > routerY)
    begin
      dir = portNorth;
    end
    else if (hdr.destY < routerY)
    begin
      dir = portSouth;
    end
    else
    begin
      dir = portLocal;
    end
    return dir;
  endfunction

  assign hdrIn = inFlit.payload;

  // take a new flit only once the previous handshake has closed.
  assign capture = inReq && !inAck && !bufValid;

  // ##############################
  // handshake and buffer state
  // ##############################

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      inAck    <= 1'b0;
      bufValid <= 1'b0;
      route    <= portLocal;
    end
    else
    begin
      if (capture)
      begin
        inAck    <= 1'b1;
        bufValid <= 1'b1;
        if (inFlit.kind == headerFlit)
        begin
          route <= xyRoute(hdrIn);
        end
      end
      else
      begin
        if (inAck && !inReq)
        begin
          inAck <= 1'b0;
        end
        if (pop)
        begin
          bufValid <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      bufFlit <= inFlit;
    end
  end

  // body flits reuse the route of their header.
  assign reqVec = bufValid ? (numPorts'(1) << route) : '0;

endmodule

`default_nettype wire

/* design/nocRouter.sv */
`default_nettype none
`timescale 1ns/10ps

module nocRouter #(
  parameter logic [nocRouterPkg::coordWidth-1:0] routerX = '0,
  parameter logic [nocRouterPkg::coordWidth-1:0] routerY = '0
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [4:0]               inReq,
  input  nocRouterPkg::flitT [4:0] inFlit,
  output logic [4:0]               inAck,
  output logic [4:0]               outReq,
  output nocRouterPkg::flitT [4:0] outFlit,
  input  logic [4:0]               outAck
);

  import nocRouterPkg::*;

  logic [numPorts-1:0]         bufValid;
  flitT [numPorts-1:0]         bufFlit;
  logic [numPorts-1:0]         reqVec [numPorts];
  logic [numPorts-1:0]         arbReq [numPorts];
  arbStateE                    grant [numPorts];
  logic [numPorts-1:0]         popVec [numPorts];
  logic [numPorts-1:0]         pop;
  logic [numPorts-1:0]         sent;
  flitT [numPorts-1:0]         sentFlit;

  // receiver i requests output o on reqVec[i][o], arbiter o sees it as arbReq[o][i].
  always_comb
  begin
    for (int o = 0; o < numPorts; o++)
    begin
      for (int i = 0; i < numPorts; i++)
      begin
        arbReq[o][i] = reqVec[i][o];
      end
    end
  end

  // an input is served by at most one output at a time.
  always_comb
  begin
    pop = '0;
    for (int o = 0; o < numPorts; o++)
    begin
      pop = pop | popVec[o];
    end
  end

  // ##############################
  // per-port slices
  // ##############################

  for (genvar p = 0; p < numPorts; p++)
  begin : portSlice
    linkReceiver #(
      .routerX (routerX),
      .routerY (routerY)
    ) receiver (
      .clk      (clk),
      .rst      (rst),
      .inReq    (inReq[p]),
      .inFlit   (inFlit[p]),
      .inAck    (inAck[p]),
      .pop      (pop[p]),
      .bufValid (bufValid[p]),
      .bufFlit  (bufFlit[p]),
      .reqVec   (reqVec[p])
    );

    switchArbiter arbiter (
      .clk      (clk),
      .rst      (rst),
      .reqVec   (arbReq[p]),
      .sent     (sent[p]),
      .sentFlit (sentFlit[p]),
      .grant    (grant[p])
    );

    crossbarSender sender (
      .clk      (clk),
      .rst      (rst),
      .grant    (grant[p]),
      .bufValid (bufValid),
      .bufFlit  (bufFlit),
      .popVec   (popVec[p]),
      .sent     (sent[p]),
      .sentFlit (sentFlit[p]),
      .outReq   (outReq[p]),
      .outFlit  (outFlit[p]),
      .outAck   (outAck[p])
    );
  end

endmodule

`default_nettype wire

/* design/nocRouterPkg.sv */
`default_nettype none

package nocRouterPkg;

  // ##############################
  // sizes
  // ##############################

  localparam int numPorts = 5;
  localparam int lengthWidth = 12;
  localparam int coordWidth = 2;

  // ##############################
  // encodings
  // ##############################

  typedef enum logic [2:0] {
    idleFlit   = 3'd0,
    headerFlit = 3'd1,
    bodyFlit   = 3'd2
  } flitKindE;

  // port index, also the bit position in every per-port vector.
  typedef enum logic [2:0] {
    portLocal = 3'd0,
    portNorth = 3'd1,
    portEast  = 3'd2,
    portWest  = 3'd3,
    portSouth = 3'd4
  } portE;

  // bit 0 is idle, bit p+1 grants input port p.
  typedef enum logic [5:0] {
    arbIdle    = 6'b000001,
    grantLocal = 6'b000010,
    grantNorth = 6'b000100,
    grantEast  = 6'b001000,
    grantWest  = 6'b010000,
    grantSouth = 6'b100000
  } arbStateE;

  // length counts every flit of the packet, header included.
  typedef struct packed {
    logic [coordWidth-1:0]  destX;
    logic [coordWidth-1:0]  destY;
    logic [lengthWidth-1:0] length;
  } headerT;

  typedef struct packed {
    flitKindE    kind;
    logic [15:0] payload;
  } flitT;

endpackage

`default_nettype wire

/* design/switchArbiter.sv */
`default_nettype none
`timescale 1ns/10ps

module switchArbiter (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [4:0]             reqVec,
  input  logic                   sent,
  input  nocRouterPkg::flitT     sentFlit,
  output nocRouterPkg::arbStateE grant
);

  import nocRouterPkg::*;

  arbStateE               state;
  arbStateE               stateNext;
  portE                   curPort;
  headerT                 sentHdr;
  logic [lengthWidth-1:0] flitCount;
  logic [lengthWidth-1:0] pktLength;
  logic                   pktFinished;
  logic                   holdGrant;

  // first requester among span ports, starting at port first and wrapping.
  function automatic arbStateE scanReq(logic [numPorts-1:0] req, int first, int span);
    arbStateE pick;
    logic     found;
    int       idx;
    pick  = arbIdle;
    found = 1'b0;
    for (int k = 0; k < numPorts; k++)
    begin
      idx = (first + k) % numPorts;
      if (!found && (k < span) && req[idx])
      begin
        pick  = arbStateE'(6'b000010 << idx);
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  assign grant   = state;
  assign sentHdr = sentFlit.payload;

  always_comb
  begin
    case (state)
      grantNorth: curPort = portNorth;
      grantEast:  curPort = portEast;
      grantWest:  curPort = portWest;
      grantSouth: curPort = portSouth;
      default:    curPort = portLocal;
    endcase
  end

  // ##############################
  // packet length counter
  // ##############################

  // count of zero means the header has not gone out yet.
  assign pktFinished = (flitCount != '0) && (flitCount == pktLength);

  // the input buffer empties between flits, so an open packet holds the grant
  // even while its request is low.
  assign holdGrant = !pktFinished && (reqVec[curPort] || (flitCount != '0));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      flitCount <= '0;
    end
    else if (stateNext != state)
    begin
      flitCount <= '0;
    end
    else if (sent)
    begin
      if (sentFlit.kind == headerFlit)
      begin
        flitCount <= lengthWidth'(1);
      end
      else
      begin
        flitCount <= flitCount + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sent && (sentFlit.kind == headerFlit))
    begin
      pktLength <= sentHdr.length;
    end
  end

  // ##############################
  // grant state machine
  // ##############################

  always_comb
  begin
    stateNext = state;
    case (state)
      arbIdle:
      begin
        stateNext = scanReq(reqVec, int'(portLocal), numPorts);
      end
      grantLocal, grantNorth, grantEast, grantWest, grantSouth:
      begin
        if (!holdGrant)
        begin
          // rotation starts after the current port and skips it.
          stateNext = scanReq(reqVec, int'(curPort) + 1, numPorts - 1);
        end
      end
      default:
      begin
        stateNext = arbIdle;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= arbIdle;
    end
    else
    begin
      state <= stateNext;
    end
  end

endmodule

`default_nettype wire

/* nocRouter.f */
design/nocRouterPkg.sv
design/linkReceiver.sv
design/switchArbiter.sv
design/crossbarSender.sv
design/nocRouter.sv
tb/nocRouter_asserts.sv
tb/nocRouterTb.sv

/* tb/nocRouterTb.sv */
`default_nettype none
`timescale 1ns/10ps

module nocRouterTb;

  import nocRouterPkg::*;

  logic                clk;
  logic                rst;
  logic [numPorts-1:0] inReq;
  flitT [numPorts-1:0] inFlit;
  logic [numPorts-1:0] inAck;
  logic [numPorts-1:0] outReq;
  flitT [numPorts-1:0] outFlit;
  logic [numPorts-1:0] outAck;

  flitT        pkts [numPorts][$];
  flitT        expQ [numPorts][$];
  int          startDelay [numPorts];
  int          ackDelayMax [numPorts];
  time         doneAt [numPorts];
  logic [31:0] lcgState = 32'he556ae82;
  int          errors = 0;
  int          testsRun = 0;
  int          testsFailed = 0;
  int          testStartErrors = 0;
  int          waitLimit = 400;
  int          hereX = 1;
  int          hereY = 1;

  nocRouter #(
    .routerX (2'd1),
    .routerY (2'd1)
  ) DUT (
    .clk    (clk),
    .rst    (rst),
    .inReq  (inReq),
    .inFlit (inFlit),
    .inAck  (inAck),
    .outReq (outReq),
    .outFlit(outFlit),
    .outAck (outAck)
  );

  bind nocRouter nocRouter_asserts protocolChecks (
    .clk    (clk),
    .rst    (rst),
    .inReq  (inReq),
    .inAck  (inAck),
    .outReq (outReq),
    .outFlit(outFlit),
    .outAck (outAck),
    .grant  (grant),
    .popVec (popVec)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // X is resolved before Y.
  function automatic int routeFor(int dx, int dy);
    int dir;
    dir = int'(portLocal);
    if (dx != hereX)
    begin
      dir = (dx > hereX) ? int'(portEast) : int'(portWest);
    end
    else if (dy != hereY)
    begin
      dir = (dy > hereY) ? int'(portNorth) : int'(portSouth);
    end
    return dir;
  endfunction

  function automatic int totalErrors();
    return errors + DUT.protocolChecks.violations;
  endfunction

  task automatic finishRun();
    int total;
    total = totalErrors();
    $display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, total);
    if (total == 0)
    begin
      $display("Verification passed");
    end
    else
    begin
      $display("Verification failed");
    end
    $finish;
  endtask

  // ##############################
  // link handshakes
  // ##############################

  task automatic waitInAck(input int p, input logic level);
    int n;
    n = 0;
    while (inAck[p] !== level && n < waitLimit)
    begin
      @(negedge clk);
      n++;
    end
    if (inAck[p] !== level)
    begin
      errors++;
      $display("timeout: inAck[%0d] did not go to %0d in %0d cycles", p, level, waitLimit);
      finishRun();
    end
  endtask

  task automatic waitOutReq(input int p, input logic level);
    int n;
    n = 0;
    while (outReq[p] !== level && n < waitLimit)
    begin
      @(negedge clk);
      n++;
    end
    if (outReq[p] !== level)
    begin
      errors++;
      $display("timeout: outReq[%0d] did not go to %0d in %0d cycles", p, level, waitLimit);
      finishRun();
    end
  endtask

  task automatic sendFlit(input int p, input flitT f);
    @(negedge clk);
    inFlit[p] = f;
    inReq[p] = 1'b1;
    waitInAck(p, 1'b1);
    inReq[p] = 1'b0;
    waitInAck(p, 1'b0);
  endtask

  task automatic sendPacket(input int p);
    repeat (startDelay[p]) @(negedge clk);
    while (pkts[p].size() > 0)
    begin
      sendFlit(p, pkts[p].pop_front());
    end
  endtask

  // the flit is compared once outReq is seen high, then acked after a random delay.
  task automatic acceptFlits(input int p, input int count);
    flitT exp;
    flitT got;
    int   delay;
    for (int k = 0; k < count; k++)
    begin
      waitOutReq(p, 1'b1);
      got = outFlit[p];
      exp = expQ[p].pop_front();
      assert (got == exp)
      else
      begin
        errors++;
        $display("FAILED outFlit[%0d]: expected %h, got %h", p, exp, got);
      end
      delay = int'(nextRand() >> 20) % (ackDelayMax[p] + 1);
      repeat (delay) @(negedge clk);
      outAck[p] = 1'b1;
      waitOutReq(p, 1'b0);
      outAck[p] = 1'b0;
    end
    doneAt[p] = $time;
  endtask

  // ##############################
  // traffic and scoreboard
  // ##############################

  task automatic clearTraffic();
    for (int p = 0; p < numPorts; p++)
    begin
      pkts[p].delete();
      expQ[p].delete();
      startDelay[p] = 0;
      ackDelayMax[p] = 2;
      doneAt[p] = 0;
    end
  endtask

  // builds the packet for input p and books it on its routed output.
  task automatic queuePacket(input int p, input int dx, input int dy, input int len);
    flitT f;
    int   dest;
    dest = routeFor(dx, dy);
    f.kind = headerFlit;
    f.payload = {2'(dx), 2'(dy), 12'(len)};
    pkts[p].push_back(f);
    expQ[dest].push_back(f);
    for (int k = 1; k < len; k++)
    begin
      f.kind = bodyFlit;
      f.payload = 16'(nextRand() >> 8);
      pkts[p].push_back(f);
      expQ[dest].push_back(f);
    end
  endtask

  task automatic checkIdle();
    assert (inAck == '0)
    else
    begin
      errors++;
      $display("FAILED inAck: expected %h, got %h", 5'h0, inAck);
    end
    assert (outReq == '0)
    else
    begin
      errors++;
      $display("FAILED outReq: expected %h, got %h", 5'h0, outReq);
    end
  endtask

  task automatic runTraffic();
    int count [numPorts];
    for (int o = 0; o < numPorts; o++)
    begin
      count[o] = expQ[o].size();
    end
    for (int p = 0; p < numPorts; p++)
    begin
      fork
        automatic int q = p;
        sendPacket(q);
      join_none
      fork
        automatic int q = p;
        acceptFlits(q, count[q]);
      join_none
    end
    wait fork;
    repeat (4) @(negedge clk);
    checkIdle();
  endtask

  task automatic endTest(input string name);
    int now;
    now = totalErrors();
    testsRun++;
    if (now == testStartErrors)
    begin
      $display("test %0d, %s: ok", testsRun, name);
    end
    else
    begin
      testsFailed++;
      $display("test %0d, %s: %0d errors", testsRun, name, now - testStartErrors);
    end
    testStartErrors = now;
  endtask

  // ##############################
  // test sequence
  // ##############################

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    inReq = '0;
    inFlit = '0;
    outAck = '0;
    clearTraffic();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    repeat (10)
    begin
      @(negedge clk);
      checkIdle();
    end
    endTest("quiet after reset");

    // one destination per run, lengths 1 to 4.
    clearTraffic();
    queuePacket(int'(portEast), 1, 1, 1);
    runTraffic();
    clearTraffic();
    queuePacket(int'(portSouth), 1, 3, 2);
    runTraffic();
    clearTraffic();
    queuePacket(int'(portLocal), 3, 0, 3);
    runTraffic();
    clearTraffic();
    queuePacket(int'(portNorth), 0, 2, 4);
    runTraffic();
    clearTraffic();
    queuePacket(int'(portWest), 1, 0, 2);
    runTraffic();
    endTest("single packet per destination");

    // west holds east; rotation then serves south before local.
    clearTraffic();
    queuePacket(int'(portWest), 3, 1, 4);
    queuePacket(int'(portSouth), 2, 2, 2);
    queuePacket(int'(portLocal), 3, 3, 3);
    startDelay[int'(portSouth)] = 4;
    startDelay[int'(portLocal)] = 4;
    runTraffic();
    endTest("shared output and rotation");

    clearTraffic();
    ackDelayMax[int'(portNorth)] = 12;
    queuePacket(int'(portLocal), 1, 3, 4);
    queuePacket(int'(portWest), 1, 2, 2);
    queuePacket(int'(portEast), 1, 0, 3);
    runTraffic();
    // the free south output finishes while north is still busy.
    assert (doneAt[int'(portSouth)] < doneAt[int'(portNorth)])
    else
    begin
      errors++;
      $display("south output did not finish before the slow north output");
    end
    endTest("slow output beside a free one");

    clearTraffic();
    queuePacket(int'(portLocal), 2, 1, 3);
    queuePacket(int'(portNorth), 1, 0, 2);
    queuePacket(int'(portEast), 0, 1, 4);
    queuePacket(int'(portWest), 1, 2, 1);
    queuePacket(int'(portSouth), 1, 1, 3);
    runTraffic();
    endTest("five packets in parallel");

    finishRun();
  end

endmodule

`default_nettype wire

/* tb/nocRouter_asserts.sv */
`default_nettype none
`timescale 1ns/10ps

module nocRouter_asserts (
  input logic                                            clk,
  input logic                                            rst,
  input logic [nocRouterPkg::numPorts-1:0]               inReq,
  input logic [nocRouterPkg::numPorts-1:0]               inAck,
  input logic [nocRouterPkg::numPorts-1:0]               outReq,
  input nocRouterPkg::flitT [nocRouterPkg::numPorts-1:0] outFlit,
  input logic [nocRouterPkg::numPorts-1:0]               outAck,
  input nocRouterPkg::arbStateE                          grant [nocRouterPkg::numPorts],
  input logic [nocRouterPkg::numPorts-1:0]               popVec [nocRouterPkg::numPorts]
);

  import nocRouterPkg::*;

  int                  violations = 0;
  flitT [numPorts-1:0] lastFlit;
  logic [numPorts-1:0] lastReq;
  logic [numPorts-1:0] flitMoved;
  logic [numPorts-1:0] grantBad;
  logic [numPorts-1:0] popClash;

  always_ff @(posedge clk)
  begin
    lastFlit <= outFlit;
    lastReq  <= outReq;
  end

  always_comb
  begin
    logic [numPorts-1:0] takers;
    for (int o = 0; o < numPorts; o++)
    begin
      flitMoved[o] = lastReq[o] && outReq[o] && (outFlit[o] != lastFlit[o]);
      grantBad[o]  = !$onehot(grant[o]);
    end
    // column i collects the pops that every output sends to input i.
    for (int i = 0; i < numPorts; i++)
    begin
      for (int o = 0; o < numPorts; o++)
      begin
        takers[o] = popVec[o][i];
      end
      popClash[i] = !$onehot0(takers);
    end
  end

  // ##############################
  // protocol checks
  // ##############################

  // the receiver answers the req it sampled one cycle earlier.
  inAckRise: assert property (@(posedge clk) disable iff (rst)
    (inAck & ~$past(inAck) & ~$past(inReq)) == '0)
  else
  begin
    violations++;
    $error("inAck rose on an input whose inReq was low");
  end

  outAckRise: assert property (@(posedge clk) disable iff (rst)
    (outAck & ~$past(outAck) & ~outReq) == '0)
  else
  begin
    violations++;
    $error("outAck rose on an output whose outReq was low");
  end

  outFlitHeld: assert property (@(posedge clk) disable iff (rst) flitMoved == '0)
  else
  begin
    violations++;
    $error("outFlit changed while outReq was high");
  end

  grantOneHot: assert property (@(posedge clk) disable iff (rst) grantBad == '0)
  else
  begin
    violations++;
    $error("an arbiter grant is neither one-hot nor idle");
  end

  popSingle: assert property (@(posedge clk) disable iff (rst) popClash == '0)
  else
  begin
    violations++;
    $error("an input was popped by two outputs in one cycle");
  end

endmodule

`default_nettype wire
